//--- rtl/mipsPkg.sv
`default_nettype none

package mipsPkg;

	////////////////////////////////////////////////////////////////////////////
	// widths
	////////////////////////////////////////////////////////////////////////////

	// data path and address width
	localparam int wordWidth = 32;
	// register number
	localparam int regAddrWidth = 5;
	// data ram holds 2**memDepthLog2 words
	localparam int memDepthLog2 = 8;

	////////////////////////////////////////////////////////////////////////////
	// instruction encodings
	////////////////////////////////////////////////////////////////////////////

	// primary opcodes in instr[31:26]
	localparam logic [5:0] opRtype = 6'h00;
	localparam logic [5:0] opJ = 6'h02;
	localparam logic [5:0] opBeq = 6'h04;
	localparam logic [5:0] opAddiu = 6'h09;
	localparam logic [5:0] opOri = 6'h0d;
	localparam logic [5:0] opLui = 6'h0f;
	localparam logic [5:0] opLw = 6'h23;
	localparam logic [5:0] opSw = 6'h2b;

	// r-type function field in instr[5:0]
	localparam logic [5:0] fnAddu = 6'h21;
	localparam logic [5:0] fnSubu = 6'h23;
	localparam logic [5:0] fnAnd = 6'h24;
	localparam logic [5:0] fnOr = 6'h25;
	localparam logic [5:0] fnSlt = 6'h2a;

	// alu operations, aluAdd is the zero value
	typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluSlt, aluLui} aluOpT;

	// writeback source
	typedef enum logic {resAlu, resMem} resultSrcT;

	// decode control, all zero is a bubble
	typedef struct packed {
		logic regWrite;
		resultSrcT resultSrc;
		logic memWrite;
		logic branch;
		logic jump;
		logic aluSrcImm;
		logic regDstRd;
		logic zeroExtImm;
		aluOpT aluOp;
	} ctrlT;

	// execute operand source
	typedef enum logic [1:0] {fwdNone, fwdMem, fwdWb} fwdSelT;

endpackage

`default_nettype wire

//--- rtl/memBus.sv
`timescale 1ns/1ps
`default_nettype none

// datapath to data ram, one word per access
interface memBus import mipsPkg::*; ();
	// byte address, low two bits zero
	logic [wordWidth-1:0] addr;
	logic [wordWidth-1:0] writeData;
	// write strobe, taken on the rising edge
	logic writeEnable;
	// follows addr combinationally
	logic [wordWidth-1:0] readData;

	modport master (output addr, output writeData, output writeEnable, input readData);
	modport slave (input addr, input writeData, input writeEnable, output readData);
endinterface

`default_nettype wire

//--- rtl/instrDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module instrDecoder import mipsPkg::*; (
	input wire [wordWidth-1:0] instr,
	output ctrlT ctrl
);

	logic [5:0] opcode;
	logic [5:0] funct;

	assign opcode = instr[31:26];
	assign funct = instr[5:0];

	// main decode plus alu decode in one pass
	always_comb begin
		ctrl = '0;
		case (opcode)
			opRtype: begin
				// rd destination, both operands from registers
				ctrl.regWrite = 1'b1;
				ctrl.regDstRd = 1'b1;
				case (funct)
					fnAddu: ctrl.aluOp = aluAdd;
					fnSubu: ctrl.aluOp = aluSub;
					fnAnd: ctrl.aluOp = aluAnd;
					fnOr: ctrl.aluOp = aluOr;
					fnSlt: ctrl.aluOp = aluSlt;
					// sll zero and any other function is a no-op
					default: ctrl = '0;
				endcase
			end
			opAddiu: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.aluOp = aluAdd;
			end
			opOri: begin
				// logical immediates are zero extended
				ctrl.regWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.zeroExtImm = 1'b1;
				ctrl.aluOp = aluOr;
			end
			opLui: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.aluOp = aluLui;
			end
			opLw: begin
				// address is base plus signed offset
				ctrl.regWrite = 1'b1;
				ctrl.resultSrc = resMem;
				ctrl.aluSrcImm = 1'b1;
				ctrl.aluOp = aluAdd;
			end
			opSw: begin
				ctrl.memWrite = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.aluOp = aluAdd;
			end
			// compare happens in decode, the alu is idle
			opBeq: ctrl.branch = 1'b1;
			opJ: ctrl.jump = 1'b1;
			default: ctrl = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- rtl/hazardUnit.sv
`timescale 1ns/1ps
`default_nettype none

module hazardUnit import mipsPkg::*; (
	input wire [regAddrWidth-1:0] rsD,
	input wire [regAddrWidth-1:0] rtD,
	input wire branchD,
	input wire jumpD,
	input wire takenD,
	input wire [regAddrWidth-1:0] rsE,
	input wire [regAddrWidth-1:0] rtE,
	input wire [regAddrWidth-1:0] writeRegE,
	input wire regWriteE,
	input wire memToRegE,
	input wire [regAddrWidth-1:0] writeRegM,
	input wire regWriteM,
	input wire memToRegM,
	input wire [regAddrWidth-1:0] writeRegW,
	input wire regWriteW,
	output logic stallF,
	output logic stallD,
	output logic flushD,
	output logic flushE,
	output logic forwardAD,
	output logic forwardBD,
	output fwdSelT forwardAE,
	output fwdSelT forwardBE
);

	logic hitE;
	logic hitM;
	logic lwStall;
	logic branchStall;

	// newest producer wins, $0 never forwards
	function automatic fwdSelT pickFwd(input logic [regAddrWidth-1:0] src);
		if (src != '0 && regWriteM && src == writeRegM)
			return fwdMem;
		else if (src != '0 && regWriteW && src == writeRegW)
			return fwdWb;
		else
			return fwdNone;
	endfunction

	always_comb begin
		forwardAE = pickFwd(rsE);
		forwardBE = pickFwd(rtE);
	end

	// branch compare only takes alu results from memory
	// writeback comes through the register file bypass
	assign forwardAD = (rsD != '0) && regWriteM && (rsD == writeRegM);
	assign forwardBD = (rtD != '0) && regWriteM && (rtD == writeRegM);

	// decode sources written by execute or memory
	assign hitE = regWriteE && (writeRegE != '0) && (writeRegE == rsD || writeRegE == rtD);
	assign hitM = regWriteM && (writeRegM != '0) && (writeRegM == rsD || writeRegM == rtD);

	// load in execute feeding decode
	assign lwStall = memToRegE && hitE;
	// branch waits for alu results to reach memory, loads to reach writeback
	assign branchStall = branchD && (hitE || (memToRegM && hitM));

	assign stallD = lwStall || branchStall;
	assign stallF = stallD;
	// held decode leaves a bubble behind it
	assign flushE = stallD;
	// redirect drops the fetched slot once decode moves on
	assign flushD = (takenD || jumpD) && !stallD;

endmodule

`default_nettype wire

//--- rtl/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile import mipsPkg::*; (
	input wire clk,
	input wire we,
	input wire [regAddrWidth-1:0] ra1,
	input wire [regAddrWidth-1:0] ra2,
	input wire [regAddrWidth-1:0] wa,
	input wire [wordWidth-1:0] wd,
	output logic [wordWidth-1:0] rd1,
	output logic [wordWidth-1:0] rd2
);

	logic [wordWidth-1:0] regs [0:(1 << regAddrWidth) - 1];

	always_ff @(posedge clk) begin
		if (we && wa != '0) begin
			regs[wa] <= wd;
		end
	end

	// $0 reads zero, same-cycle write passes straight through
	assign rd1 = (ra1 == '0) ? '0 : ((we && wa == ra1) ? wd : regs[ra1]);
	assign rd2 = (ra2 == '0) ? '0 : ((we && wa == ra2) ? wd : regs[ra2]);

	// writeback filters $0 before it gets here
	assert property (@(posedge clk) we |-> (wa != '0));

endmodule

`default_nettype wire

//--- rtl/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu import mipsPkg::*; (
	input wire [wordWidth-1:0] a,
	input wire [wordWidth-1:0] b,
	input wire aluOpT op,
	output logic [wordWidth-1:0] y
);

	logic lessThan;

	// signed compare for slt
	assign lessThan = $signed(a) < $signed(b);

	always_comb begin
		case (op)
			// addu and addiu, no overflow trap
			aluAdd: y = a + b;
			aluSub: y = a - b;
			aluAnd: y = a & b;
			aluOr: y = a | b;
			aluSlt: y = {{(wordWidth - 1){1'b0}}, lessThan};
			// immediate into the upper half
			aluLui: y = {b[15:0], {(wordWidth - 16){1'b0}}};
			default: y = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- rtl/datapath.sv
`timescale 1ns/1ps
`default_nettype none

module datapath import mipsPkg::*; (
	input wire clk,
	input wire reset,
	output logic [wordWidth-1:0] pc,
	input wire [wordWidth-1:0] instr,
	memBus.master mem,
	output logic wbValid,
	output logic [wordWidth-1:0] wbPc,
	output logic [regAddrWidth-1:0] wbRegNum,
	output logic [wordWidth-1:0] wbRegData
);

	// hazard controls
	logic stallF, stallD, flushD, flushE;
	logic forwardAD, forwardBD;
	fwdSelT forwardAE, forwardBE;
	// fetch
	logic [wordWidth-1:0] pcPlus4F, pcNext;
	// decode
	logic [wordWidth-1:0] instrD, pcD, pcPlus4D;
	ctrlT ctrlD;
	logic [regAddrWidth-1:0] rsD, rtD, rdD;
	logic [wordWidth-1:0] immD, rd1D, rd2D, cmpAD, cmpBD;
	logic [wordWidth-1:0] branchTargetD, jumpTargetD;
	logic takenD;
	// execute
	ctrlT ctrlE;
	logic [wordWidth-1:0] rd1E, rd2E, immE, pcE;
	logic [regAddrWidth-1:0] rsE, rtE, rdE, writeRegE;
	logic [wordWidth-1:0] srcAE, writeDataE, srcBE, aluOutE;
	// memory
	ctrlT ctrlM;
	logic [wordWidth-1:0] aluOutM, writeDataM, pcM;
	logic [regAddrWidth-1:0] writeRegM;
	// writeback
	ctrlT ctrlW;
	logic [wordWidth-1:0] aluOutW, readDataW, resultW, pcW;
	logic [regAddrWidth-1:0] writeRegW;

	// execute operand select
	function automatic logic [wordWidth-1:0] fwdMux(input fwdSelT sel,
			input logic [wordWidth-1:0] regVal, input logic [wordWidth-1:0] memVal,
			input logic [wordWidth-1:0] wbVal);
		case (sel)
			fwdMem: return memVal;
			fwdWb: return wbVal;
			default: return regVal;
		endcase
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// fetch
	////////////////////////////////////////////////////////////////////////////

	assign pcPlus4F = pc + wordWidth'(4);
	// jump and taken branch redirect from decode
	assign pcNext = ctrlD.jump ? jumpTargetD : (takenD ? branchTargetD : pcPlus4F);

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
		end else if (!stallF) begin
			pc <= pcNext;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// decode
	////////////////////////////////////////////////////////////////////////////

	// zero word decodes as a bubble
	always_ff @(posedge clk) begin
		if (reset || flushD) begin
			instrD <= '0;
		end else if (!stallD) begin
			instrD <= instr;
		end
	end

	always_ff @(posedge clk) begin
		if (!stallD) begin
			pcD <= pc;
		end
	end

	instrDecoder uDecoder (.instr(instrD), .ctrl(ctrlD));

	assign rsD = instrD[25:21];
	assign rtD = instrD[20:16];
	assign rdD = instrD[15:11];
	assign pcPlus4D = pcD + wordWidth'(4);

	// ori zero extends, everything else sign extends
	assign immD = ctrlD.zeroExtImm ? {{(wordWidth - 16){1'b0}}, instrD[15:0]}
		: {{(wordWidth - 16){instrD[15]}}, instrD[15:0]};

	regFile uRegFile (
		.clk(clk),
		.we(wbValid),
		.ra1(rsD),
		.ra2(rtD),
		.wa(writeRegW),
		.wd(resultW),
		.rd1(rd1D),
		.rd2(rd2D)
	);

	// beq compare, memory stage bypass
	assign cmpAD = forwardAD ? aluOutM : rd1D;
	assign cmpBD = forwardBD ? aluOutM : rd2D;
	assign takenD = ctrlD.branch && (cmpAD == cmpBD);
	assign branchTargetD = pcPlus4D + {immD[wordWidth-3:0], 2'b00};
	assign jumpTargetD = {pcPlus4D[wordWidth-1:28], instrD[25:0], 2'b00};

	hazardUnit uHazard (
		.rsD(rsD),
		.rtD(rtD),
		.branchD(ctrlD.branch),
		.jumpD(ctrlD.jump),
		.takenD(takenD),
		.rsE(rsE),
		.rtE(rtE),
		.writeRegE(writeRegE),
		.regWriteE(ctrlE.regWrite),
		.memToRegE(ctrlE.resultSrc == resMem),
		.writeRegM(writeRegM),
		.regWriteM(ctrlM.regWrite),
		.memToRegM(ctrlM.resultSrc == resMem),
		.writeRegW(writeRegW),
		.regWriteW(ctrlW.regWrite),
		.stallF(stallF),
		.stallD(stallD),
		.flushD(flushD),
		.flushE(flushE),
		.forwardAD(forwardAD),
		.forwardBD(forwardBD),
		.forwardAE(forwardAE),
		.forwardBE(forwardBE)
	);

	////////////////////////////////////////////////////////////////////////////
	// execute
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset || flushE) begin
			ctrlE <= '0;
		end else begin
			ctrlE <= ctrlD;
		end
	end

	always_ff @(posedge clk) begin
		rd1E <= rd1D;
		rd2E <= rd2D;
		immE <= immD;
		rsE <= rsD;
		rtE <= rtD;
		rdE <= rdD;
		pcE <= pcD;
	end

	assign srcAE = fwdMux(forwardAE, rd1E, aluOutM, resultW);
	// forwarded rt is also the store data
	assign writeDataE = fwdMux(forwardBE, rd2E, aluOutM, resultW);
	assign srcBE = ctrlE.aluSrcImm ? immE : writeDataE;
	assign writeRegE = ctrlE.regDstRd ? rdE : rtE;

	alu uAlu (.a(srcAE), .b(srcBE), .op(ctrlE.aluOp), .y(aluOutE));

	////////////////////////////////////////////////////////////////////////////
	// memory
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			ctrlM <= '0;
		end else begin
			ctrlM <= ctrlE;
		end
	end

	always_ff @(posedge clk) begin
		aluOutM <= aluOutE;
		writeDataM <= writeDataE;
		writeRegM <= writeRegE;
		pcM <= pcE;
	end

	assign mem.addr = aluOutM;
	assign mem.writeData = writeDataM;
	assign mem.writeEnable = ctrlM.memWrite;

	// stores never carry a register write down the pipe
	assert property (@(posedge clk) ctrlM.memWrite |-> !ctrlM.regWrite);

	////////////////////////////////////////////////////////////////////////////
	// writeback
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			ctrlW <= '0;
		end else begin
			ctrlW <= ctrlM;
		end
	end

	always_ff @(posedge clk) begin
		aluOutW <= aluOutM;
		readDataW <= mem.readData;
		writeRegW <= writeRegM;
		pcW <= pcM;
	end

	assign resultW = (ctrlW.resultSrc == resMem) ? readDataW : aluOutW;

	// debug report, writes to $0 drop out here
	assign wbValid = ctrlW.regWrite && (writeRegW != '0);
	assign wbPc = pcW;
	assign wbRegNum = writeRegW;
	assign wbRegData = resultW;

endmodule

`default_nettype wire

//--- rtl/dataMem.sv
`timescale 1ns/1ps
`default_nettype none

module dataMem import mipsPkg::*; (
	input wire clk,
	memBus.slave bus
);

	// starts cleared
	logic [wordWidth-1:0] ram [0:(1 << memDepthLog2) - 1] = '{default: '0};
	logic [memDepthLog2-1:0] wordAddr;

	// byte address to word index
	assign wordAddr = bus.addr[memDepthLog2+1:2];

	always_ff @(posedge clk) begin
		if (bus.writeEnable) begin
			ram[wordAddr] <= bus.writeData;
		end
	end

	// asynchronous read
	assign bus.readData = ram[wordAddr];

	// only whole words are stored
	assert property (@(posedge clk) bus.writeEnable |-> (bus.addr[1:0] == 2'b00));

endmodule

`default_nettype wire

//--- rtl/mipsCore.sv
`timescale 1ns/1ps
`default_nettype none

module mipsCore import mipsPkg::*; (
	input wire clk,
	input wire reset,
	output wire [wordWidth-1:0] pc,
	input wire [wordWidth-1:0] instr,
	output wire wbValid,
	output wire [wordWidth-1:0] wbPc,
	output wire [regAddrWidth-1:0] wbRegNum,
	output wire [wordWidth-1:0] wbRegData
);

	// load and store path
	memBus dBus ();

	// pipeline, instruction memory sits outside
	datapath uDatapath (
		.clk(clk),
		.reset(reset),
		.pc(pc),
		.instr(instr),
		.mem(dBus.master),
		.wbValid(wbValid),
		.wbPc(wbPc),
		.wbRegNum(wbRegNum),
		.wbRegData(wbRegData)
	);

	dataMem uDataMem (
		.clk(clk),
		.bus(dBus.slave)
	);

endmodule

`default_nettype wire

//--- sim/tbMipsCore.sv
`timescale 1ns/1ps
`default_nettype none

module tbMipsCore import mipsPkg::*; ();

	// instruction words in the program table
	localparam int progLen = 30;
	// writebacks the program must report
	localparam int expLen = 20;
	// worst case six cycles per instruction plus pipeline fill
	localparam int timeoutCycles = progLen * 6 + 30;
	// byte offset of the word used by sw and lw
	localparam logic [15:0] memOffset = 16'h0040;

	logic clk;
	logic reset;
	logic [wordWidth-1:0] instr;
	wire [wordWidth-1:0] pc;
	wire wbValid;
	wire [wordWidth-1:0] wbPc;
	wire [regAddrWidth-1:0] wbRegNum;
	wire [wordWidth-1:0] wbRegData;

	// instruction rom image
	logic [wordWidth-1:0] progRom [0:progLen-1];
	// expected writebacks, in program order
	string expName [0:expLen-1];
	logic [regAddrWidth-1:0] expReg [0:expLen-1];
	logic [wordWidth-1:0] expData [0:expLen-1];
	logic [wordWidth-1:0] expPc [0:expLen-1];
	int expCount;
	int checkIdx;
	int cycleCount;

	mipsCore uut (
		.clk(clk),
		.reset(reset),
		.pc(pc),
		.instr(instr),
		.wbValid(wbValid),
		.wbPc(wbPc),
		.wbRegNum(wbRegNum),
		.wbRegData(wbRegData)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// instruction encoding
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] encodeR(input logic [4:0] rs, input logic [4:0] rt,
			input logic [4:0] rd, input logic [5:0] fn);
		return {opRtype, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic logic [31:0] encodeI(input logic [5:0] op, input logic [4:0] rs,
			input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// target is the word index of the destination
	function automatic logic [31:0] encodeJ(input logic [5:0] op, input logic [25:0] target);
		return {op, target};
	endfunction

	function automatic logic [31:0] signExt16(input logic [15:0] v);
		return {{16{v[15]}}, v};
	endfunction

	// append one expected report, idx is the word index of the producer
	task automatic expectWb(input string name, input logic [4:0] regNum,
			input logic [31:0] value, input int idx);
		expName[expCount] = name;
		expReg[expCount] = regNum;
		expData[expCount] = value;
		expPc[expCount] = 32'(idx * 4);
		expCount++;
	endtask

	task automatic checkValue(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("ERR %s expected %h actual %h", name, expected, actual);
			$display("SOME TESTS FAILED");
			$fatal(1, "writeback mismatch");
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// program and expected results
	////////////////////////////////////////////////////////////////////////////

	task automatic buildProgram();
		logic [15:0] immA;
		logic [15:0] immB;
		logic [15:0] immC;
		logic [31:0] sa;
		logic [31:0] zb;
		logic [31:0] uc;
		logic [31:0] r9;
		int i;
		immA = 16'($urandom);
		immB = 16'($urandom);
		immC = 16'($urandom);
		// addiu sign extends, ori zero extends, lui shifts up
		sa = signExt16(immA);
		zb = {16'h0000, immB};
		uc = {immC, 16'h0000};
		r9 = sa + 32'd5;
		for (i = 0; i < progLen; i++) begin
			progRom[i] = '0;
		end
		expCount = 0;
		// independent alu ops
		progRom[0] = encodeI(opAddiu, 5'd0, 5'd1, immA);
		expectWb("addiu", 5'd1, sa, 0);
		progRom[1] = encodeI(opOri, 5'd0, 5'd2, immB);
		expectWb("ori", 5'd2, zb, 1);
		progRom[2] = encodeI(opLui, 5'd0, 5'd3, immC);
		expectWb("lui", 5'd3, uc, 2);
		progRom[4] = encodeR(5'd1, 5'd2, 5'd4, fnAddu);
		expectWb("addu", 5'd4, sa + zb, 4);
		progRom[5] = encodeR(5'd1, 5'd2, 5'd5, fnSubu);
		expectWb("subu", 5'd5, sa - zb, 5);
		progRom[6] = encodeR(5'd1, 5'd3, 5'd6, fnAnd);
		expectWb("and", 5'd6, sa & uc, 6);
		progRom[7] = encodeR(5'd2, 5'd3, 5'd7, fnOr);
		expectWb("or", 5'd7, zb | uc, 7);
		progRom[8] = encodeR(5'd1, 5'd2, 5'd8, fnSlt);
		expectWb("slt", 5'd8, ($signed(sa) < $signed(zb)) ? 32'd1 : 32'd0, 8);
		// back to back, memory then writeback forwarding
		progRom[9] = encodeI(opAddiu, 5'd1, 5'd9, 16'd5);
		expectWb("fwd producer", 5'd9, r9, 9);
		progRom[10] = encodeR(5'd9, 5'd9, 5'd10, fnAddu);
		expectWb("fwd mem", 5'd10, r9 + r9, 10);
		progRom[11] = encodeR(5'd9, 5'd10, 5'd11, fnSubu);
		expectWb("fwd mem and wb", 5'd11, r9 - (r9 + r9), 11);
		// store, load back, then load-use
		progRom[12] = encodeI(opSw, 5'd0, 5'd4, memOffset);
		progRom[13] = encodeI(opLw, 5'd0, 5'd12, memOffset);
		expectWb("lw after sw", 5'd12, sa + zb, 13);
		progRom[14] = encodeR(5'd12, 5'd1, 5'd13, fnAddu);
		expectWb("load use", 5'd13, sa + zb + sa, 14);
		// $0 target gives no report, reads stay zero
		progRom[15] = encodeI(opAddiu, 5'd0, 5'd0, immC);
		progRom[16] = encodeR(5'd0, 5'd1, 5'd14, fnAddu);
		expectWb("read zero", 5'd14, sa, 16);
		// taken beq right after its load, lands on word 21
		progRom[17] = encodeI(opLw, 5'd0, 5'd15, memOffset);
		expectWb("lw for beq", 5'd15, sa + zb, 17);
		progRom[18] = encodeI(opBeq, 5'd15, 5'd4, 16'd2);
		progRom[19] = encodeI(opAddiu, 5'd0, 5'd16, 16'd1);
		progRom[20] = encodeI(opAddiu, 5'd0, 5'd17, 16'd2);
		progRom[21] = encodeI(opAddiu, 5'd0, 5'd18, 16'd3);
		expectWb("beq target", 5'd18, 32'd3, 21);
		// not taken beq on a fresh alu result
		progRom[22] = encodeI(opAddiu, 5'd0, 5'd19, 16'd7);
		expectWb("beq producer", 5'd19, 32'd7, 22);
		progRom[23] = encodeI(opBeq, 5'd19, 5'd0, 16'd1);
		progRom[24] = encodeI(opAddiu, 5'd19, 5'd20, 16'd1);
		expectWb("beq fall through", 5'd20, 32'd8, 24);
		// jump over two words
		progRom[25] = encodeJ(opJ, 26'd28);
		progRom[26] = encodeI(opAddiu, 5'd0, 5'd21, 16'd9);
		progRom[27] = encodeI(opAddiu, 5'd0, 5'd22, 16'd10);
		progRom[28] = encodeI(opAddiu, 5'd0, 5'd23, 16'd11);
		expectWb("j target", 5'd23, 32'd11, 28);
		progRom[29] = encodeR(5'd18, 5'd20, 5'd24, fnAddu);
		expectWb("after j", 5'd24, 32'd11, 29);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// instruction rom and checking
	////////////////////////////////////////////////////////////////////////////

	// rom answers the current pc, nop past the end
	always @(negedge clk) begin
		if (pc[wordWidth-1:2] < progLen) begin
			instr = progRom[pc[wordWidth-1:2]];
		end else begin
			instr = '0;
		end
	end

	initial begin
		void'($urandom(32'h68b8_d1a0));
		reset = 1'b1;
		instr = '0;
		checkIdx = 0;
		cycleCount = 0;
		buildProgram();
		repeat (8) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		// reports are stable mid cycle
		while (checkIdx < expLen && cycleCount < timeoutCycles) begin
			@(negedge clk);
			cycleCount++;
			if (wbValid) begin
				checkValue({expName[checkIdx], " reg"}, 32'(expReg[checkIdx]), 32'(wbRegNum));
				checkValue({expName[checkIdx], " data"}, expData[checkIdx], wbRegData);
				checkValue({expName[checkIdx], " pc"}, expPc[checkIdx], wbPc);
				checkIdx++;
			end
		end
		if (checkIdx == expLen) begin
			$display("ALL TESTS PASSED");
			$finish;
		end else begin
			$display("timeout after %0d cycles, only %0d of %0d expected writebacks arrived",
				cycleCount, checkIdx, expLen);
			$display("SOME TESTS FAILED");
			$fatal(1, "timeout");
		end
	end

endmodule

`default_nettype wire

//--- vlog.f
rtl/mipsPkg.sv
rtl/memBus.sv
rtl/instrDecoder.sv
rtl/hazardUnit.sv
rtl/regFile.sv
rtl/alu.sv
rtl/datapath.sv
rtl/dataMem.sv
rtl/mipsCore.sv
sim/tbMipsCore.sv

//--- Bender.yml
package:
  name: mipsCore

sources:
  - rtl/mipsPkg.sv
  - rtl/memBus.sv
  - rtl/instrDecoder.sv
  - rtl/hazardUnit.sv
  - rtl/regFile.sv
  - rtl/alu.sv
  - rtl/datapath.sv
  - rtl/dataMem.sv
  - rtl/mipsCore.sv
  - target: test
    files:
      - sim/tbMipsCore.sv
